// ==== source/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// number of general registers
`define CPU_REG_COUNT 32

`endif

// ==== source/isa_pkg.sv ====
package isa_pkg;

	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OPCODE_W   = 6;
	localparam int FUNCT_W    = 6;
	localparam int SHAMT_W    = 5;
	localparam int IMM_W      = 16;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [SHAMT_W-1:0]    shamt_t;
	typedef logic [IMM_W-1:0]      imm_t;

	// major opcodes of the supported subset
	typedef enum logic [OPCODE_W-1:0] {
		OP_SPECIAL = 6'h00,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f
	} opcode_t;

	// function field under SPECIAL
	typedef enum logic [FUNCT_W-1:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_t;

endpackage

// ==== source/pipe_pkg.sv ====
package pipe_pkg;

	import isa_pkg::*;

	typedef enum logic [3:0] {
		ALU_NOP,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI
	} alu_op_t;

	// register write request, also the commit trace
	typedef struct packed {
		logic      we;
		reg_addr_t waddr;
		word_t     wdata;
		word_t     pc;
	} reg_wr_t;

	// one decoded instruction
	typedef struct packed {
		logic      valid;
		word_t     pc;
		alu_op_t   alu_op;
		word_t     operand1;
		word_t     operand2;
		shamt_t    shamt;
		reg_addr_t waddr;
		logic      we;
	} pipe_data_t;

endpackage

// ==== source/reg_read_if.sv ====
`timescale 1ns/1ps

interface reg_read_if;
	import isa_pkg::*;

	reg_addr_t raddr1;
	reg_addr_t raddr2;
	word_t     rdata1;
	word_t     rdata2;

	modport reg_side(input raddr1, input raddr2, output rdata1, output rdata2);
	modport reader(output raddr1, output raddr2, input rdata1, input rdata2);

endinterface

// ==== source/regs.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module regs(
	input  logic               clk,
	input  logic               rst_n,
	input  pipe_pkg::reg_wr_t  wr1,
	input  pipe_pkg::reg_wr_t  wr2,
	reg_read_if.reg_side       rd_a,
	reg_read_if.reg_side       rd_b
);
	import isa_pkg::*;

	word_t gpr [`CPU_REG_COUNT];

	// write-through with port 2 as the younger write
	function automatic word_t read_gpr(input reg_addr_t addr);
		word_t value;
		if (addr == '0) begin
			value = '0;
		end else if (wr2.we && wr2.waddr == addr) begin
			value = wr2.wdata;
		end else if (wr1.we && wr1.waddr == addr) begin
			value = wr1.wdata;
		end else begin
			value = gpr[addr];
		end
		return value;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				gpr[i] <= '0;
			end
		end else begin
			// r0 stays zero
			if (wr1.we && wr1.waddr != '0) begin
				gpr[wr1.waddr] <= wr1.wdata;
			end
			if (wr2.we && wr2.waddr != '0) begin
				gpr[wr2.waddr] <= wr2.wdata;
			end
		end
	end

	always_comb begin
		rd_a.rdata1 = read_gpr(rd_a.raddr1);
		rd_a.rdata2 = read_gpr(rd_a.raddr2);
		rd_b.rdata1 = read_gpr(rd_b.raddr1);
		rd_b.rdata2 = read_gpr(rd_b.raddr2);
	end

endmodule

// ==== source/reg_pc.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module reg_pc(
	input  logic           clk,
	input  logic           rst_n,
	input  logic           issue_b,
	output isa_pkg::word_t pc
);
	import isa_pkg::*;

	word_t step;

	// one or two instructions consumed
	assign step = issue_b ? 32'd8 : 32'd4;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `CPU_RESET_PC;
		end else begin
			pc <= pc + step;
		end
	end

endmodule

// ==== source/cpu_id.sv ====
`timescale 1ns/1ps

module cpu_id(
	input  isa_pkg::word_t       pc,
	input  isa_pkg::word_t       inst,
	reg_read_if.reader           rd,
	input  pipe_pkg::reg_wr_t    fwd_a,
	input  pipe_pkg::reg_wr_t    fwd_b,
	output pipe_pkg::pipe_data_t data
);
	import isa_pkg::*;
	import pipe_pkg::*;

	opcode_t   opcode;
	funct_t    funct;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd_field;
	shamt_t    shamt;
	imm_t      imm;
	alu_op_t   alu_op;
	reg_addr_t waddr;
	logic      we;
	logic      use_imm;
	logic      sign_ext;
	word_t     imm_ext;

	assign opcode   = opcode_t'(inst[31:26]);
	assign rs       = inst[25:21];
	assign rt       = inst[20:16];
	assign rd_field = inst[15:11];
	assign shamt    = inst[10:6];
	assign funct    = funct_t'(inst[5:0]);
	assign imm      = inst[15:0];

	assign rd.raddr1 = rs;
	assign rd.raddr2 = rt;

	// slot b is younger than slot a
	function automatic word_t forward(input reg_addr_t addr, input word_t regval);
		word_t value;
		if (fwd_b.we && fwd_b.waddr == addr) begin
			value = fwd_b.wdata;
		end else if (fwd_a.we && fwd_a.waddr == addr) begin
			value = fwd_a.wdata;
		end else begin
			value = regval;
		end
		return value;
	endfunction

	always_comb begin
		alu_op   = ALU_NOP;
		waddr    = rt;
		we       = 1'b1;
		use_imm  = 1'b1;
		sign_ext = 1'b0;
		case (opcode)
			OP_SPECIAL: begin
				waddr   = rd_field;
				use_imm = 1'b0;
				case (funct)
					FN_SLL:  alu_op = ALU_SLL;
					FN_SRL:  alu_op = ALU_SRL;
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_NOR:  alu_op = ALU_NOR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_SLTU: alu_op = ALU_SLTU;
					default: we = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				alu_op   = ALU_ADD;
				sign_ext = 1'b1;
			end
			OP_SLTI: begin
				alu_op   = ALU_SLT;
				sign_ext = 1'b1;
			end
			OP_ANDI: alu_op = ALU_AND;
			OP_ORI:  alu_op = ALU_OR;
			OP_XORI: alu_op = ALU_XOR;
			OP_LUI:  alu_op = ALU_LUI;
			// unknown encoding runs as a nop
			default: we = 1'b0;
		endcase
	end

	assign imm_ext = sign_ext ? {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm}
	                          : {{(WORD_W-IMM_W){1'b0}}, imm};

	always_comb begin
		data.valid    = 1'b1;
		data.pc       = pc;
		data.alu_op   = alu_op;
		data.operand1 = forward(rs, rd.rdata1);
		data.operand2 = use_imm ? imm_ext : forward(rt, rd.rdata2);
		data.shamt    = shamt;
		data.waddr    = waddr;
		data.we       = we && (waddr != '0);
	end

endmodule

// ==== source/superscalar_ctrl.sv ====
`timescale 1ns/1ps

module superscalar_ctrl(
	input  pipe_pkg::pipe_data_t data_a,
	input  pipe_pkg::pipe_data_t data_b,
	input  isa_pkg::word_t       inst_b,
	output logic                 issue_b
);
	import isa_pkg::*;

	reg_addr_t rs_b;
	reg_addr_t rt_b;
	logic      raw_hazard;
	logic      waw_hazard;

	assign rs_b = inst_b[25:21];
	assign rt_b = inst_b[20:16];

	// decode never sets we for r0
	assign raw_hazard = data_a.we && (data_a.waddr == rs_b || data_a.waddr == rt_b);
	assign waw_hazard = data_a.we && data_b.we && (data_a.waddr == data_b.waddr);

	assign issue_b = !(raw_hazard || waw_hazard);

endmodule

// ==== source/id_ex.sv ====
`timescale 1ns/1ps

module id_ex(
	input  logic                 clk,
	input  logic                 rst_n,
	input  pipe_pkg::pipe_data_t id_a,
	input  pipe_pkg::pipe_data_t id_b,
	input  logic                 issue_b,
	output pipe_pkg::pipe_data_t ex_a,
	output pipe_pkg::pipe_data_t ex_b
);
	import pipe_pkg::*;

	logic       valid_a;
	logic       valid_b;
	pipe_data_t payload_a;
	pipe_data_t payload_b;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_a <= 1'b0;
			valid_b <= 1'b0;
		end else begin
			valid_a <= id_a.valid;
			// pipe b is dropped here and refetched as next pipe a
			valid_b <= id_b.valid && issue_b;
		end
	end

	always_ff @(posedge clk) begin
		payload_a <= id_a;
		payload_b <= id_b;
	end

	always_comb begin
		ex_a       = payload_a;
		ex_a.valid = valid_a;
		ex_b       = payload_b;
		ex_b.valid = valid_b;
	end

endmodule

// ==== source/cpu_ex.sv ====
`timescale 1ns/1ps

module cpu_ex(
	input  logic                 clk,
	input  logic                 rst_n,
	input  pipe_pkg::pipe_data_t data,
	output pipe_pkg::reg_wr_t    fwd,
	output pipe_pkg::reg_wr_t    wb
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t   result;
	logic    wb_we;
	reg_wr_t wb_payload;

	always_comb begin
		case (data.alu_op)
			ALU_ADD:  result = data.operand1 + data.operand2;
			ALU_SUB:  result = data.operand1 - data.operand2;
			ALU_AND:  result = data.operand1 & data.operand2;
			ALU_OR:   result = data.operand1 | data.operand2;
			ALU_XOR:  result = data.operand1 ^ data.operand2;
			ALU_NOR:  result = ~(data.operand1 | data.operand2);
			ALU_SLT:  result = {31'b0, $signed(data.operand1) < $signed(data.operand2)};
			ALU_SLTU: result = {31'b0, data.operand1 < data.operand2};
			// shifts act on the rt value
			ALU_SLL:  result = data.operand2 << data.shamt;
			ALU_SRL:  result = data.operand2 >> data.shamt;
			ALU_LUI:  result = {data.operand2[15:0], 16'h0000};
			default:  result = '0;
		endcase
	end

	always_comb begin
		fwd.we    = data.valid && data.we;
		fwd.waddr = data.waddr;
		fwd.wdata = result;
		fwd.pc    = data.pc;
	end

	// writeback stage
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_we <= 1'b0;
		end else begin
			wb_we <= fwd.we;
		end
	end

	always_ff @(posedge clk) begin
		wb_payload <= fwd;
	end

	always_comb begin
		wb    = wb_payload;
		wb.we = wb_we;
	end

endmodule

// ==== source/trivial_mips.sv ====
`timescale 1ns/1ps

module trivial_mips(
	input  logic                 clk,
	input  logic                 rst_n,
	output isa_pkg::word_t       inst_addr,
	input  isa_pkg::word_t       inst_rdata,
	input  isa_pkg::word_t       inst_rdata_2,
	output logic                 commit_we_a,
	output isa_pkg::word_t       commit_pc_a,
	output isa_pkg::reg_addr_t   commit_waddr_a,
	output isa_pkg::word_t       commit_wdata_a,
	output logic                 commit_we_b,
	output isa_pkg::word_t       commit_pc_b,
	output isa_pkg::reg_addr_t   commit_waddr_b,
	output isa_pkg::word_t       commit_wdata_b
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t      if_pc;
	word_t      pc_b;
	logic       issue_b;
	pipe_data_t data_id_a;
	pipe_data_t data_id_b;
	pipe_data_t data_ex_a;
	pipe_data_t data_ex_b;
	reg_wr_t    fwd_a;
	reg_wr_t    fwd_b;
	reg_wr_t    wb_a;
	reg_wr_t    wb_b;

	reg_read_if rd_if_a();
	reg_read_if rd_if_b();

	reg_pc pc_instance(
		.clk,
		.rst_n,
		.issue_b,
		.pc(if_pc)
	);

	assign inst_addr = if_pc;
	assign pc_b      = if_pc + 32'd4;

	regs general_regs_instance(
		.clk,
		.rst_n,
		.wr1(wb_a),
		.wr2(wb_b),
		.rd_a(rd_if_a),
		.rd_b(rd_if_b)
	);

	cpu_id stage_id_a(
		.pc(if_pc),
		.inst(inst_rdata),
		.rd(rd_if_a),
		.fwd_a,
		.fwd_b,
		.data(data_id_a)
	);

	cpu_id stage_id_b(
		.pc(pc_b),
		.inst(inst_rdata_2),
		.rd(rd_if_b),
		.fwd_a,
		.fwd_b,
		.data(data_id_b)
	);

	superscalar_ctrl superscalar_ctrl_instance(
		.data_a(data_id_a),
		.data_b(data_id_b),
		.inst_b(inst_rdata_2),
		.issue_b
	);

	id_ex stage_id_ex(
		.clk,
		.rst_n,
		.id_a(data_id_a),
		.id_b(data_id_b),
		.issue_b,
		.ex_a(data_ex_a),
		.ex_b(data_ex_b)
	);

	cpu_ex stage_ex_a(
		.clk,
		.rst_n,
		.data(data_ex_a),
		.fwd(fwd_a),
		.wb(wb_a)
	);

	cpu_ex stage_ex_b(
		.clk,
		.rst_n,
		.data(data_ex_b),
		.fwd(fwd_b),
		.wb(wb_b)
	);

	// commit trace is the regfile write request
	assign commit_we_a    = wb_a.we;
	assign commit_pc_a    = wb_a.pc;
	assign commit_waddr_a = wb_a.waddr;
	assign commit_wdata_a = wb_a.wdata;
	assign commit_we_b    = wb_b.we;
	assign commit_pc_b    = wb_b.pc;
	assign commit_waddr_b = wb_b.waddr;
	assign commit_wdata_b = wb_b.wdata;

endmodule

// ==== tests/tb_trivial_mips.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_trivial_mips;

	localparam int RESET_CYCLES = 10;
	localparam int DRIVE_DELAY = 1;
	localparam int MEM_WORDS = 256;
	localparam int SWEEP_FIRST = 240;
	localparam logic [31:0] SWEEP_PC = 32'd960;
	// only nops remain past the sweep
	localparam logic [31:0] END_PC = 32'd992;
	localparam int MAX_GROUPS = 400;

	logic        clk = 1'b0;
	logic        rst_n;
	logic [31:0] inst_addr;
	logic [31:0] inst_rdata;
	logic [31:0] inst_rdata_2;
	logic        commit_we_a;
	logic [31:0] commit_pc_a;
	logic [4:0]  commit_waddr_a;
	logic [31:0] commit_wdata_a;
	logic        commit_we_b;
	logic [31:0] commit_pc_b;
	logic [4:0]  commit_waddr_b;
	logic [31:0] commit_wdata_b;

	logic [31:0] mem [MEM_WORDS];
	logic [7:0]  fetch_idx;
	logic [31:0] model_regs [`CPU_REG_COUNT];
	bit          written [`CPU_REG_COUNT];
	bit          swept [`CPU_REG_COUNT];
	logic [31:0] model_pc;
	logic [15:0] lfsr;
	int          checks;
	int          errors;
	int          assert_errors = 0;
	int          paired;
	int          split;
	bit          timed_out;

	trivial_mips uut(
		.clk,
		.rst_n,
		.inst_addr,
		.inst_rdata,
		.inst_rdata_2,
		.commit_we_a,
		.commit_pc_a,
		.commit_waddr_a,
		.commit_wdata_a,
		.commit_we_b,
		.commit_pc_b,
		.commit_waddr_b,
		.commit_wdata_b
	);

	always #50 clk = ~clk;

	// instruction memory wraps at 256 words
	assign fetch_idx    = inst_addr[9:2];
	assign inst_rdata   = mem[fetch_idx];
	assign inst_rdata_2 = mem[fetch_idx + 8'd1];

	// slot b only ever commits the word after slot a
	assert property (@(posedge clk) disable iff (!rst_n)
		commit_we_b |-> commit_pc_b == commit_pc_a + 32'd4)
	else begin
		assert_errors++;
		$display("CHECK FAILED at %0t: slot b pc %h not paired with slot a pc %h",
			$time, $sampled(commit_pc_b), $sampled(commit_pc_a));
	end

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [31:0] rand_bits(input int count);
		logic [31:0] value;
		logic        fb;
		value = '0;
		for (int i = 0; i < count; i++) begin
			fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr  = {lfsr[14:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	function automatic logic [31:0] encode_inst(input int cls, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh,
		input logic [15:0] imm);
		logic [5:0] op;
		logic [5:0] fn;
		op = 6'h00;
		fn = 6'h00;
		case (cls)
			0: fn = 6'h00;
			1: fn = 6'h02;
			2: fn = 6'h21;
			3: fn = 6'h23;
			4: fn = 6'h24;
			5: fn = 6'h25;
			6: fn = 6'h26;
			7: fn = 6'h27;
			8: fn = 6'h2a;
			9: fn = 6'h2b;
			10: op = 6'h09;
			11: op = 6'h0a;
			12: op = 6'h0c;
			13: op = 6'h0d;
			14: op = 6'h0e;
			15: op = 6'h0f;
			// unused major opcode
			16: op = 6'h3f;
			default: fn = 6'h3f;
		endcase
		if (cls < 10 || cls > 16) begin
			return {op, rs, rt, rd, (cls < 2) ? sh : 5'd0, fn};
		end
		return {op, rs, rt, imm};
	endfunction

	task automatic load_program();
		int          cls;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  sh;
		logic [15:0] imm;
		lfsr = 16'd25;
		for (int i = 0; i < SWEEP_FIRST; i++) begin
			cls = int'(rand_bits(5) % 32'd18);
			rs  = 5'(rand_bits(3));
			rt  = 5'(rand_bits(3));
			rd  = 5'(rand_bits(3));
			sh  = 5'(rand_bits(5));
			imm = 16'(rand_bits(16));
			mem[8'(i)] = encode_inst(cls, rs, rt, rd, sh, imm);
		end
		// ori rk, rk, 0 reads each register back
		for (int k = 1; k < 8; k++) begin
			mem[8'(SWEEP_FIRST + k - 1)] = {6'h0d, 5'(k), 5'(k), 16'h0000};
		end
		for (int i = SWEEP_FIRST + 7; i < MEM_WORDS; i++) begin
			mem[8'(i)] = 32'h0000_0000;
		end
	endtask

	// ISA result of one instruction against the model registers
	function automatic void expected_write(input logic [31:0] inst, output logic we,
		output logic [4:0] waddr, output logic [31:0] wdata);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] zimm;
		logic        known;
		a     = model_regs[inst[25:21]];
		b     = model_regs[inst[20:16]];
		simm  = {{16{inst[15]}}, inst[15:0]};
		zimm  = {16'h0000, inst[15:0]};
		known = 1'b1;
		waddr = inst[20:16];
		wdata = '0;
		case (inst[31:26])
			6'h00: begin
				waddr = inst[15:11];
				case (inst[5:0])
					6'h00: wdata = b << inst[10:6];
					6'h02: wdata = b >> inst[10:6];
					6'h21: wdata = a + b;
					6'h23: wdata = a - b;
					6'h24: wdata = a & b;
					6'h25: wdata = a | b;
					6'h26: wdata = a ^ b;
					6'h27: wdata = ~(a | b);
					6'h2a: wdata = {31'b0, $signed(a) < $signed(b)};
					6'h2b: wdata = {31'b0, a < b};
					default: known = 1'b0;
				endcase
			end
			6'h09: wdata = a + simm;
			6'h0a: wdata = {31'b0, $signed(a) < $signed(simm)};
			6'h0c: wdata = a & zimm;
			6'h0d: wdata = a | zimm;
			6'h0e: wdata = a ^ zimm;
			6'h0f: wdata = {inst[15:0], 16'h0000};
			default: known = 1'b0;
		endcase
		we = known && waddr != 5'd0;
	endfunction

	task automatic verify(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s", $time, msg);
		end
	endtask

	// seen tells whether the DUT committed this write with the model value
	task automatic retire(input logic [31:0] pc, input logic [4:0] waddr,
		input logic [31:0] wdata, input logic seen);
		model_regs[waddr] = wdata;
		if (pc >= SWEEP_PC) begin
			swept[waddr] = seen;
		end else begin
			written[waddr] = 1'b1;
		end
	endtask

	// one decode group with pipe a at model_pc and pipe b at model_pc + 4
	task automatic check_group();
		logic [7:0]  idx;
		logic [31:0] inst_a;
		logic [31:0] inst_b;
		logic        we_a;
		logic        we_b;
		logic [4:0]  waddr_a;
		logic [4:0]  waddr_b;
		logic [31:0] wdata_a;
		logic [31:0] wdata_b;
		logic        pair;
		idx    = model_pc[9:2];
		inst_a = mem[idx];
		inst_b = mem[idx + 8'd1];
		expected_write(inst_a, we_a, waddr_a, wdata_a);
		verify(commit_pc_a == model_pc,
			$sformatf("slot a pc %h, expected %h", commit_pc_a, model_pc));
		verify(commit_we_a == we_a,
			$sformatf("slot a pc %h we %b, expected %b", model_pc, commit_we_a, we_a));
		if (we_a) begin
			verify(commit_waddr_a == waddr_a && commit_wdata_a == wdata_a,
				$sformatf("slot a pc %h wrote r%0d=%h, expected r%0d=%h", model_pc,
				commit_waddr_a, commit_wdata_a, waddr_a, wdata_a));
			retire(model_pc, waddr_a, wdata_a,
				commit_we_a && commit_waddr_a == waddr_a && commit_wdata_a == wdata_a);
		end
		expected_write(inst_b, we_b, waddr_b, wdata_b);
		// rs and rt fields of b count as sources
		pair = !(we_a && (waddr_a == inst_b[25:21] || waddr_a == inst_b[20:16]))
			&& !(we_a && we_b && waddr_a == waddr_b);
		if (pair) begin
			verify(commit_we_b == we_b,
				$sformatf("slot b pc %h we %b, expected %b", model_pc + 32'd4,
				commit_we_b, we_b));
			if (we_b) begin
				verify(commit_pc_b == model_pc + 32'd4 && commit_waddr_b == waddr_b
					&& commit_wdata_b == wdata_b,
					$sformatf("slot b pc %h wrote r%0d=%h, expected pc %h r%0d=%h",
					commit_pc_b, commit_waddr_b, commit_wdata_b, model_pc + 32'd4,
					waddr_b, wdata_b));
				retire(model_pc + 32'd4, waddr_b, wdata_b,
					commit_we_b && commit_pc_b == model_pc + 32'd4
					&& commit_waddr_b == waddr_b && commit_wdata_b == wdata_b);
			end
			paired++;
			model_pc = model_pc + 32'd8;
		end else begin
			verify(!commit_we_b,
				$sformatf("slot b committed pc %h of a conflicting pair", commit_pc_b));
			split++;
			model_pc = model_pc + 32'd4;
		end
	endtask

	initial begin
		int groups;
		rst_n     = 1'b0;
		model_pc  = `CPU_RESET_PC;
		checks    = 0;
		errors    = 0;
		paired    = 0;
		split     = 0;
		timed_out = 1'b0;
		groups    = 0;
		for (int k = 0; k < `CPU_REG_COUNT; k++) begin
			model_regs[5'(k)] = '0;
			written[5'(k)]    = 1'b0;
			swept[5'(k)]      = 1'b0;
		end
		load_program();

		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk);
		end
		#DRIVE_DELAY rst_n = 1'b1;

		// two cycles of pipeline fill before the first commit
		@(negedge clk);
		verify(inst_addr == `CPU_RESET_PC, $sformatf("fetch address %h after reset", inst_addr));
		verify(!commit_we_a && !commit_we_b, "commit enable set right after reset");
		@(negedge clk);
		verify(!commit_we_a && !commit_we_b, "commit enable set before first result");

		while (model_pc < END_PC && !timed_out) begin
			@(negedge clk);
			check_group();
			groups++;
			if (groups >= MAX_GROUPS && model_pc < END_PC) begin
				timed_out = 1'b1;
			end
		end

		if (timed_out) begin
			$display("timeout: program end %h not reached within %0d cycles", END_PC, MAX_GROUPS);
		end else begin
			for (int k = 1; k < 8; k++) begin
				if (written[5'(k)]) begin
					verify(swept[5'(k)],
						$sformatf("r%0d was not read back with its model value", k));
				end
			end
		end

		$display("checks %0d, errors %0d, assertion errors %0d, paired %0d, split %0d",
			checks, errors, assert_errors, paired, split);
		if (!timed_out && errors == 0 && assert_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/reg_read_if.sv
source/regs.sv
source/reg_pc.sv
source/cpu_id.sv
source/superscalar_ctrl.sv
source/id_ex.sv
source/cpu_ex.sv
source/trivial_mips.sv
tests/tb_trivial_mips.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

# build the testbench with the core underneath it
verilator --binary --assert -j 0 --top-module tb_trivial_mips -f src.f -Mdir obj_dir -o sim

output="$(./obj_dir/sim)"
echo "$output"

if echo "$output" | grep -q "Test completed successfully"; then
	exit 0
else
	exit 1
fi
